//--- files.f
+incdir+include
+incdir+sim
logic/pocket_pkg.sv
logic/status_regs.sv
logic/video_timing.sv
logic/status_overlay.sv
logic/i2s_framer.sv
logic/pocket_core.sv
sim/tb_pocket_core.sv

//--- Makefile
# Verilator build and run for the pocket core testbench

TOP := tb_pocket_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		-f files.f --top-module $(TOP) -Mdir obj_dir

# pass only if the exact pass line shows up in the output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf obj_dir

//--- sim/tb_checks.svh
/*
 * testbench reference model and compare tasks
 * expected pixel colour and register read data
 * and one compare task per result type
 */

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

//////////////////////
// reference model
//////////////////////

// boxes are 20 wide but both edges count so box 0 spans 0..20
function automatic rgb_t ref_pixel(input coord_t x, input coord_t y, input status_t st);
    int   box;
    rgb_t c;
    c = '0;
    box = (x == '0) ? 0 : (int'(x) - 1) / `BOX_W;
    if (int'(y) <= `BOX_H && box < `BOX_COUNT) begin
        case (box)
            0: if (st.red)   c = 24'hFF0000;
            1: if (st.green) c = 24'h00FF00;
            2: if (st.blue)  c = 24'h0000FF;
            3: if (st.blink) c = 24'hFFFFFF;
            4: if (st.error) c = 24'h7F7F00;
            default: c = '0;
        endcase
    end
    return c;
endfunction

// zero-extended register contents and zero for unmapped reads
function automatic apb_data_t ref_read(input apb_addr_t addr, input status_t st,
                                       input frame_cnt_t fc);
    apb_data_t d;
    d = '0;
    if (addr == `REG_STATUS) begin
        d[4:0] = st;
    end else if (addr == `REG_FRAME) begin
        d[15:0] = fc;
    end
    return d;
endfunction

//////////////////////
// compare tasks
//////////////////////

task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
    if (got !== exp) begin
        $display("FAIL %s got %06h expected %06h", name, got, exp);
        abort_run("pixel value mismatch");
    end
endtask

task automatic check_data(input string name, input apb_data_t got, input apb_data_t exp);
    if (got !== exp) begin
        $display("FAIL %s got %08h expected %08h", name, got, exp);
        abort_run("register data mismatch");
    end
endtask

task automatic check_frame(input string name, input frame_cnt_t got, input frame_cnt_t exp);
    if (got !== exp) begin
        $display("FAIL %s got %04h expected %04h", name, got, exp);
        abort_run("frame count mismatch");
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("FAIL %s got %0h expected %0h", name, got, exp);
        abort_run("single bit mismatch");
    end
endtask

// event counts
task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
        $display("FAIL %s got %0h expected %0h", name, got, exp);
        abort_run("event count mismatch");
    end
endtask

`endif

//--- sim/tb_pocket_core.sv
/*
 * pocket core testbench
 * APB register tests, frame timing and box colour monitor,
 * I2S bit clock and word select checks
 */

`timescale 1ns/1ps
`default_nettype none

`include "pocket_defines.svh"

module tb_pocket_core;

    import pocket_pkg::*;

    localparam int        FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
    localparam int        FRAME_PIXELS = `H_ACTIVE * `V_ACTIVE;
    localparam int        APB_TIMEOUT  = 16;
    localparam int        AUDIO_WINDOW = 600;
    localparam apb_addr_t UNMAPPED     = 8'h10;

    logic        audgen_mclk;
    logic        reset_n;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    rgb_t        video_rgb;
    logic        video_de;
    logic        video_hs;
    logic        video_vs;
    logic        audio_mclk;
    logic        audio_sclk;
    logic        audio_lrck;
    logic        audio_dac;

    // status the DUT should hold after each REG_STATUS write
    status_t     exp_status     = '0;
    logic [31:0] lfsr_state     = 32'hed49_26e1;
    int          frames_checked = 0;
    int          pixels_checked = 0;

    pocket_core u_pocket_core (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .video_rgb   (video_rgb),
        .video_de    (video_de),
        .video_hs    (video_hs),
        .video_vs    (video_vs),
        .audio_mclk  (audio_mclk),
        .audio_sclk  (audio_sclk),
        .audio_lrck  (audio_lrck),
        .audio_dac   (audio_dac)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    `include "tb_checks.svh"

    //////////////////////
    // clock, reset, random
    //////////////////////

    initial begin
        audgen_mclk = 1'b0;
        forever #20 audgen_mclk = ~audgen_mclk;
    end

    initial begin
        reset_n = 1'b0;
        repeat (5) @(posedge audgen_mclk);
        #1;
        reset_n = 1'b1;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_advance(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output apb_data_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_advance(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    //////////////////////
    // APB driver
    //////////////////////

    // setup and access phase then idle again
    // returns 1 ns after an edge
    task automatic apb_transfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                                output apb_data_t rdata, output logic err);
        int waited;
        waited = 0;
        @(posedge audgen_mclk);
        #1;
        apb_req.sel    = 1'b1;
        apb_req.enable = 1'b0;
        apb_req.write  = wr;
        apb_req.addr   = addr;
        apb_req.wdata  = wdata;
        @(posedge audgen_mclk);
        #1;
        apb_req.enable = 1'b1;
        @(negedge audgen_mclk);
        while (!apb_rsp.ready) begin
            waited++;
            if (waited > APB_TIMEOUT) abort_run("APB ready never came");
            @(negedge audgen_mclk);
        end
        rdata = apb_rsp.rdata;
        err   = apb_rsp.slverr;
        @(posedge audgen_mclk);
        #1;
        apb_req = '0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata, output logic err);
        apb_data_t unused;
        apb_transfer(1'b1, addr, wdata, unused, err);
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t rdata, output logic err);
        apb_transfer(1'b0, addr, '0, rdata, err);
    endtask

    // only the low five bits stick
    task automatic write_status(input apb_data_t data);
        apb_data_t rdata;
        logic      err;
        apb_write(`REG_STATUS, data, err);
        check_bit("pslverr REG_STATUS write", err, 1'b0);
        exp_status = status_t'(data[4:0]);
        apb_read(`REG_STATUS, rdata, err);
        check_bit("pslverr REG_STATUS read", err, 1'b0);
        check_data("prdata REG_STATUS", rdata, ref_read(`REG_STATUS, exp_status, '0));
    endtask

    //////////////////////
    // waits and idle checks
    //////////////////////

    // counts negedges up to the one that sees vsync
    task automatic wait_vs(output int waited);
        waited = 1;
        @(negedge audgen_mclk);
        while (!video_vs) begin
            waited++;
            if (waited > FRAME_CYCLES + 16) abort_run("timed out waiting for video_vs");
            @(negedge audgen_mclk);
        end
        @(posedge audgen_mclk);
        #1;
    endtask

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        while (!reset_n) begin
            waited++;
            if (waited > 16) abort_run("reset was never released");
            @(negedge audgen_mclk);
        end
    endtask

    // everything low with the apb bus idle
    task automatic check_idle_outputs();
        check_bit("video_de", video_de, 1'b0);
        check_bit("video_hs", video_hs, 1'b0);
        check_bit("video_vs", video_vs, 1'b0);
        check_rgb("video_rgb", video_rgb, '0);
        check_bit("audio_sclk", audio_sclk, 1'b0);
        check_bit("audio_lrck", audio_lrck, 1'b0);
        check_bit("audio_dac", audio_dac, 1'b0);
        check_bit("pready idle", apb_rsp.ready, 1'b0);
        check_bit("pslverr idle", apb_rsp.slverr, 1'b0);
        check_data("prdata idle", apb_rsp.rdata, '0);
    endtask

    // sclk period 4 and lrck every 128 cycles on a falling sclk
    // mclk follows the core clock in both phases
    task automatic check_audio(input int cycles);
        int   last_rise;
        int   last_lrck;
        int   toggles;
        logic prev_sclk;
        logic prev_lrck;
        last_rise = -1;
        last_lrck = -1;
        toggles   = 0;
        prev_sclk = audio_sclk;
        prev_lrck = audio_lrck;
        for (int n = 0; n < cycles; n++) begin
            @(negedge audgen_mclk);
            check_bit("audio_dac", audio_dac, 1'b0);
            if (audio_sclk && !prev_sclk) begin
                if (last_rise >= 0) check_count("audio_sclk period", n - last_rise, 4);
                last_rise = n;
            end
            if (audio_lrck != prev_lrck) begin
                check_bit("audio_sclk fall at lrck edge", prev_sclk && !audio_sclk, 1'b1);
                if (last_lrck >= 0) check_count("audio_lrck half period", n - last_lrck, 128);
                last_lrck = n;
                toggles++;
            end
            prev_sclk = audio_sclk;
            prev_lrck = audio_lrck;
            #1;
            check_bit("audio_mclk low", audio_mclk, 1'b0);
            @(posedge audgen_mclk);
            #1;
            check_bit("audio_mclk high", audio_mclk, 1'b1);
        end
        if (toggles < 2) abort_run("audio_lrck toggled too rarely to measure");
        @(posedge audgen_mclk);
        #1;
    endtask

    //////////////////////
    // video monitor
    //////////////////////

    // frame totals at each vsync and every active pixel against the box rule
    initial begin : monitor
        logic   prev_vs;
        logic   prev_hs;
        logic   seen_vs;
        int     de_cnt;
        int     hs_cnt;
        int     vs_cnt;
        coord_t px;
        coord_t py;
        prev_vs = 1'b0;
        prev_hs = 1'b0;
        seen_vs = 1'b0;
        de_cnt  = 0;
        hs_cnt  = 0;
        vs_cnt  = 0;
        forever begin
            @(negedge audgen_mclk);
            if (reset_n) begin
                if (video_vs && !prev_vs) begin
                    if (seen_vs) begin
                        check_count("video_de per frame", de_cnt, FRAME_PIXELS);
                        check_count("video_hs per frame", hs_cnt, `V_TOTAL);
                        check_count("video_vs per frame", vs_cnt, 1);
                        frames_checked++;
                    end
                    seen_vs = 1'b1;
                    de_cnt  = 0;
                    hs_cnt  = 0;
                    vs_cnt  = 0;
                end
                if (seen_vs) begin
                    if (video_vs) vs_cnt++;
                    if (video_hs && !prev_hs) hs_cnt++;
                    if (video_de) begin
                        // raster position from the de count alone
                        px = coord_t'(de_cnt % `H_ACTIVE);
                        py = coord_t'(de_cnt / `H_ACTIVE);
                        check_rgb("video_rgb", video_rgb, ref_pixel(px, py, exp_status));
                        de_cnt++;
                        pixels_checked++;
                    end
                end
            end
            prev_vs = video_vs;
            prev_hs = video_hs;
        end
    end

    //////////////////////
    // test sequence
    //////////////////////

    initial begin : main
        apb_data_t rdata;
        apb_data_t wdata;
        apb_data_t frame_before;
        apb_data_t frame_after;
        logic      err;
        int        waited;
        apb_req = '0;

        // frame counter still zero in reset
        apb_read(`REG_FRAME, rdata, err);
        check_data("prdata REG_FRAME", rdata, ref_read(`REG_FRAME, exp_status, '0));
        @(negedge audgen_mclk);
        check_idle_outputs();
        wait_reset_release();
        check_idle_outputs();
        wait_vs(waited);
        check_count("cycles from reset release to video_vs", waited, 1);

        // status write and readback with the upper bits dropped
        draw_bits(32, wdata);
        write_status(wdata);

        // unmapped address leaves status untouched
        apb_write(UNMAPPED, ~wdata, err);
        check_bit("pslverr unmapped write", err, 1'b1);
        apb_read(UNMAPPED, rdata, err);
        check_bit("pslverr unmapped read", err, 1'b1);
        check_data("prdata unmapped", rdata, ref_read(UNMAPPED, exp_status, '0));
        apb_read(`REG_STATUS, rdata, err);
        check_data("prdata REG_STATUS", rdata, ref_read(`REG_STATUS, exp_status, '0));
        // frame register is read only without an error
        apb_write(`REG_FRAME, 32'hFFFF_FFFF, err);
        check_bit("pslverr REG_FRAME write", err, 1'b0);

        check_audio(AUDIO_WINDOW);

        // one vsync gives one frame step
        apb_read(`REG_FRAME, frame_before, err);
        check_bit("pslverr REG_FRAME read", err, 1'b0);
        wait_vs(waited);
        apb_read(`REG_FRAME, frame_after, err);
        check_frame("REG_FRAME step", frame_after[15:0], frame_before[15:0] + 16'd1);
        check_data("prdata REG_FRAME", frame_after,
                   ref_read(`REG_FRAME, exp_status, frame_before[15:0] + 16'd1));

        // random status at the top of two frames
        repeat (2) begin
            draw_bits(`BOX_COUNT, wdata);
            write_status(wdata);
            wait_vs(waited);
        end

        if (frames_checked >= 3 && pixels_checked == frames_checked * FRAME_PIXELS) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            abort_run("video monitor saw fewer complete frames than the test ran");
        end
    end

endmodule

`default_nettype wire

//--- logic/pocket_core.sv
/*
 * pocket core top level
 * APB status registers, video timing, status overlay and
 * I2S silence framer, all on the 12.288 MHz mclk
 */

`timescale 1ns/1ps
`default_nettype none

module pocket_core (
    input  wire                       audgen_mclk,
    input  wire                       reset_n,

    // register access
    input  wire pocket_pkg::apb_req_t apb_req,
    output pocket_pkg::apb_rsp_t      apb_rsp,

    // video to the scaler
    output pocket_pkg::rgb_t          video_rgb,
    output logic                      video_de,
    output logic                      video_hs,
    output logic                      video_vs,

    // audio
    output logic                      audio_mclk,
    output logic                      audio_sclk,
    output logic                      audio_lrck,
    output logic                      audio_dac
);

    import pocket_pkg::*;

    status_t    status;
    video_pos_t pos;
    frame_cnt_t frame_count;

    //////////////////////
    // control
    //////////////////////

    status_regs u_status_regs (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .frame_count (frame_count),
        .status      (status)
    );

    //////////////////////
    // video
    //////////////////////

    video_timing u_video_timing (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .pos         (pos),
        .frame_count (frame_count)
    );

    status_overlay u_status_overlay (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .pos         (pos),
        .status      (status),
        .video_rgb   (video_rgb),
        .video_de    (video_de),
        .video_hs    (video_hs),
        .video_vs    (video_vs)
    );

    //////////////////////
    // audio
    //////////////////////

    i2s_framer u_i2s_framer (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .audio_sclk  (audio_sclk),
        .audio_lrck  (audio_lrck)
    );

    // mclk goes straight out to the codec
    assign audio_mclk = audgen_mclk;
    // silent stream
    assign audio_dac  = 1'b0;

endmodule

`default_nettype wire

//--- logic/i2s_framer.sv
/*
 * I2S silence framer
 * sclk = mclk / 4, word select every 32 sclk periods,
 * all clocked on mclk
 */

`timescale 1ns/1ps
`default_nettype none

`include "pocket_defines.svh"

module i2s_framer (
    input  wire  audgen_mclk,
    input  wire  reset_n,
    output logic audio_sclk,
    output logic audio_lrck
);

    logic [`SCLK_DIV_BITS-1:0] sclk_div;
    logic [`LRCK_BITS-1:0]     lrck_cnt;
    logic                      lrck_q;
    logic                      sclk_fall;

    // divider about to wrap, sclk drops on this edge
    assign sclk_fall = &sclk_div;

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            sclk_div <= '0;
            lrck_cnt <= '0;
            lrck_q   <= 1'b0;
        end else begin
            sclk_div <= sclk_div + 1'b1;
            // bit count per falling sclk
            if (sclk_fall) begin
                lrck_cnt <= lrck_cnt + 1'b1;
                // switch channels on wrap
                if (&lrck_cnt) begin
                    lrck_q <= ~lrck_q;
                end
            end
        end
    end

    // msb of the divider is the bit clock
    assign audio_sclk = sclk_div[`SCLK_DIV_BITS-1];
    assign audio_lrck = lrck_q;

    // word select moves with falling sclk only
    a_lrck_edge : assert property (
        @(posedge audgen_mclk) disable iff (!reset_n)
        $changed(audio_lrck) |-> $fell(audio_sclk)
    );

endmodule

`default_nettype wire

//--- logic/status_overlay.sv
/*
 * status box overlay
 * registers sync and data-enable, draws five coloured boxes
 * in the top-left corner from the status bits
 */

`timescale 1ns/1ps
`default_nettype none

`include "pocket_defines.svh"

module status_overlay (
    input  wire                         audgen_mclk,
    input  wire                         reset_n,
    input  wire pocket_pkg::video_pos_t pos,
    input  wire pocket_pkg::status_t    status,
    output pocket_pkg::rgb_t            video_rgb,
    output logic                        video_de,
    output logic                        video_hs,
    output logic                        video_vs
);

    import pocket_pkg::*;

    localparam int IDX_W = $clog2(`BOX_COUNT);

    logic             in_row;
    logic             box_hit;
    logic [IDX_W-1:0] box_idx;
    rgb_t             colour;

    //////////////////////
    // box select
    //////////////////////

    // edges inclusive, box 0 is 21 pixels wide
    assign in_row = (pos.vis_y <= coord_t'(`BOX_H));

    // lowest box whose right edge is not passed
    always_comb begin
        box_hit = 1'b0;
        box_idx = '0;
        for (int i = `BOX_COUNT - 1; i >= 0; i--) begin
            if (pos.vis_x <= coord_t'(`BOX_W * (i + 1))) begin
                box_hit = 1'b1;
                box_idx = IDX_W'(i);
            end
        end
    end

    always_comb begin
        colour = '0;
        if (in_row && box_hit) begin
            case (box_idx)
                0:       colour = status.red   ? 24'hFF0000 : '0;
                1:       colour = status.green ? 24'h00FF00 : '0;
                2:       colour = status.blue  ? 24'h0000FF : '0;
                3:       colour = status.blink ? 24'hFFFFFF : '0;
                4:       colour = status.error ? 24'h7F7F00 : '0;
                default: colour = '0;
            endcase
        end
    end

    //////////////////////
    // output register
    //////////////////////

    // one cycle behind pos, blanking is black
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            video_rgb <= '0;
            video_de  <= 1'b0;
            video_hs  <= 1'b0;
            video_vs  <= 1'b0;
        end else begin
            video_rgb <= pos.active ? colour : '0;
            video_de  <= pos.active;
            video_hs  <= pos.hsync;
            video_vs  <= pos.vsync;
        end
    end

endmodule

`default_nettype wire

//--- logic/video_timing.sv
/*
 * video timing generator
 * 400x512 raster at the mclk rate with 320x240 visible
 * sync flags, active window and frame counter
 */

`timescale 1ns/1ps
`default_nettype none

`include "pocket_defines.svh"

module video_timing (
    input  wire                      audgen_mclk,
    input  wire                      reset_n,
    output pocket_pkg::video_pos_t   pos,
    output pocket_pkg::frame_cnt_t   frame_count
);

    import pocket_pkg::*;

    localparam coord_t H_LAST    = coord_t'(`H_TOTAL - 1);
    localparam coord_t V_LAST    = coord_t'(`V_TOTAL - 1);
    localparam coord_t H_START   = coord_t'(`H_BPORCH);
    localparam coord_t V_START   = coord_t'(`V_BPORCH);
    localparam coord_t H_END     = coord_t'(`H_BPORCH + `H_ACTIVE);
    localparam coord_t V_END     = coord_t'(`V_BPORCH + `V_ACTIVE);
    localparam coord_t HS_POS    = coord_t'(`HS_X);

    coord_t     x_count;
    coord_t     y_count;
    frame_cnt_t frame_q;
    logic       frame_start;

    //////////////////////
    // raster counters
    //////////////////////

    assign frame_start = (x_count == '0) && (y_count == '0);

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            x_count <= '0;
            y_count <= '0;
            frame_q <= '0;
        end else begin
            if (x_count == H_LAST) begin
                x_count <= '0;
                // step to the next line and wrap at the bottom
                y_count <= (y_count == V_LAST) ? '0 : y_count + 1'b1;
            end else begin
                x_count <= x_count + 1'b1;
            end
            // counts on the edge that leaves 0,0
            if (frame_start) begin
                frame_q <= frame_q + 1'b1;
            end
        end
    end

    //////////////////////
    // position sample
    //////////////////////

    always_comb begin
        // vsync marks the new frame at 0,0
        pos.vsync  = frame_start;
        pos.hsync  = (x_count == HS_POS);
        pos.active = (x_count >= H_START) && (x_count < H_END) &&
                     (y_count >= V_START) && (y_count < V_END);
        // only meaningful when active
        pos.vis_x  = x_count - H_START;
        pos.vis_y  = y_count - V_START;
    end

    assign frame_count = frame_q;

    // x never reaches H_TOTAL
    a_x_wrap : assert property (
        @(posedge audgen_mclk) disable iff (!reset_n)
        x_count < coord_t'(`H_TOTAL)
    );

endmodule

`default_nettype wire

//--- logic/status_regs.sv
/*
 * status register block
 * APB slave, zero wait states; holds the five status bits
 * and reads back the frame counter
 */

`timescale 1ns/1ps
`default_nettype none

`include "pocket_defines.svh"

module status_regs (
    input  wire                    audgen_mclk,
    input  wire                    reset_n,
    input  wire pocket_pkg::apb_req_t apb_req,
    output pocket_pkg::apb_rsp_t   apb_rsp,
    input  wire pocket_pkg::frame_cnt_t frame_count,
    output pocket_pkg::status_t    status
);

    import pocket_pkg::*;

    logic      access;
    logic      hit_status;
    logic      hit_frame;
    logic      addr_hit;
    apb_data_t rd_value;
    status_t   status_q;

    //////////////////////
    // decode
    //////////////////////

    // access phase only, setup phase does nothing
    assign access     = apb_req.sel && apb_req.enable;
    assign hit_status = (apb_req.addr == `REG_STATUS);
    assign hit_frame  = (apb_req.addr == `REG_FRAME);
    assign addr_hit   = hit_status || hit_frame;

    // read mux, both registers zero-extended
    always_comb begin
        rd_value = '0;
        if (hit_status) begin
            rd_value[$bits(status_t)-1:0] = status_q;
        end else if (hit_frame) begin
            rd_value[$bits(frame_cnt_t)-1:0] = frame_count;
        end
    end

    //////////////////////
    // response
    //////////////////////

    // no wait states, everything low outside an access
    always_comb begin
        apb_rsp.ready  = access;
        apb_rsp.slverr = (access && !addr_hit) ? RESP_SLVERR : RESP_OKAY;
        apb_rsp.rdata  = (access && !apb_req.write) ? rd_value : '0;
    end

    //////////////////////
    // status register
    //////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            status_q <= '0;
        end else if (access && apb_req.write && hit_status) begin
            // only the low five bits are kept
            status_q <= status_t'(apb_req.wdata[$bits(status_t)-1:0]);
        end
        // writes to the frame register fall through here, no error
    end

    assign status = status_q;

    // enable only follows a setup phase with sel already high
    a_apb_phase : assert property (
        @(posedge audgen_mclk) disable iff (!reset_n)
        apb_req.enable |-> (apb_req.sel && $past(apb_req.sel))
    );

endmodule

`default_nettype wire

//--- logic/pocket_pkg.sv
/*
 * pocket core types
 * vector typedefs, the status / video position / APB structs
 * and the APB response encoding
 */

`default_nettype none

package pocket_pkg;

    // pixel or line coordinate
    typedef logic [9:0]  coord_t;
    // frames started since reset
    typedef logic [15:0] frame_cnt_t;
    // red in the upper byte
    typedef logic [23:0] rgb_t;

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // pslverr encoding
    typedef enum logic {
        RESP_OKAY   = 1'b0,
        RESP_SLVERR = 1'b1
    } apb_resp_e;

    // status bits, msb first
    typedef struct packed {
        logic error;
        logic blink;
        logic red;
        logic green;
        logic blue;
    } status_t;

    // one position sample from the timing generator
    typedef struct packed {
        coord_t vis_x;
        coord_t vis_y;
        logic   active;
        logic   hsync;
        logic   vsync;
    } video_pos_t;

    typedef struct packed {
        logic      sel;
        logic      enable;
        logic      write;
        apb_addr_t addr;
        apb_data_t wdata;
    } apb_req_t;

    typedef struct packed {
        logic      ready;
        apb_resp_e slverr;
        apb_data_t rdata;
    } apb_rsp_t;

endpackage

`default_nettype wire

//--- include/pocket_defines.svh
/*
 * pocket core constants
 * video frame geometry, status box layout, I2S divider widths
 * and APB register offsets
 */

`ifndef POCKET_DEFINES_SVH
`define POCKET_DEFINES_SVH

//////////////////////
// video geometry
//////////////////////

// 400 clocks per line, 320 visible
`define H_TOTAL   400
`define H_BPORCH  10
`define H_ACTIVE  320

// 512 lines per frame, 240 visible
`define V_TOTAL   512
`define V_BPORCH  10
`define V_ACTIVE  240

// hsync a few clocks after vsync, never on the same cycle
`define HS_X      3

//////////////////////
// status boxes
//////////////////////

`define BOX_W     20
`define BOX_H     20
`define BOX_COUNT 5

//////////////////////
// audio
//////////////////////

// mclk / 4 gives sclk
`define SCLK_DIV_BITS 2
// 32 sclk per channel
`define LRCK_BITS     5

// apb register map
`define REG_STATUS 8'h0
`define REG_FRAME  8'h4

`endif
